// File: project.f
+incdir+test
common/bf_pkg.sv
weighting/channel_weighting.sv
src/beat_fifo.sv
src/beam_combiner.sv
src/beam_former.sv
test/tb_beam_former.sv

// File: run.sh
#!/bin/sh
# builds the beamformer testbench with Verilator, runs it and searches the log for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_beam_former

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f project.f -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1

// File: test/tb_reference.svh
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// one xorshift32 step, used for samples, weights and the m_ready pattern
function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// brings one weighted part back to sample scale
// half of the last kept bit is 64 because the weight has seven fraction bits
function automatic longint weight_round(input longint part);
    longint r;
    r = (part + 64) >>> 7;
    if (r > 32767) begin
        r = 32767;
    end else if (r < -32768) begin
        r = -32768;
    end
    return r;
endfunction

// expected beam for one beat, real half when imag_part is low and imaginary half otherwise
// every channel is weighted on its own, then the four are summed and divided by four
function automatic bf_pkg::beat_u beam_ref(
    input bf_pkg::chan_beats_t                        xr,
    input bf_pkg::chan_beats_t                        xi,
    input bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] wr,
    input bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] wi,
    input logic                                       imag_part
);
    bf_pkg::beat_u beam;
    longint        sum;
    longint        part;
    longint        a_r;
    longint        a_i;
    for (int s = 0; s < bf_pkg::SAMPLES_PER_BEAT; s++) begin
        sum = 0;
        for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
            a_r = longint'($signed(xr[c].samples[s]));
            a_i = longint'($signed(xi[c].samples[s]));
            // complex product (wr + j wi)(xr + j xi)
            if (imag_part) begin
                part = longint'($signed(wr[c])) * a_i + longint'($signed(wi[c])) * a_r;
            end else begin
                part = longint'($signed(wr[c])) * a_r - longint'($signed(wi[c])) * a_i;
            end
            sum = sum + weight_round(part);
        end
        beam.samples[s] = bf_pkg::sample_t'((sum + 2) >>> 2);
    end
    return beam;
endfunction

// compares one half of an output beat with its expected value
task automatic check_beat(input string name, input bf_pkg::beat_u expected,
                          input bf_pkg::beat_u actual);
    if (actual !== expected) begin
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected.word,
                 actual.word);
        error_count++;
    end
endtask

// compares a single strobe or flag
task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
        error_count++;
    end
endtask

`endif

// File: test/tb_beam_former.sv
module tb_beam_former;

    localparam int FIFO_DEPTH = 4;
    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    // beats over all tests, 8 + 24 + 32 + 8 + 12
    localparam int TOTAL_BEATS = 84;
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_BEATS + RESET_CYCLES;
    localparam int WAIT_LIMIT = 200;

    logic                                       clock;
    logic                                       resetn;
    logic                                       s_valid;
    logic                                       s_ready;
    logic                                       s_last;
    bf_pkg::chan_beats_t                        s_real;
    bf_pkg::chan_beats_t                        s_imag;
    bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] w_real;
    bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] w_imag;
    logic                                       m_valid;
    logic                                       m_ready;
    logic                                       m_last;
    bf_pkg::beat_u                              m_real;
    bf_pkg::beat_u                              m_imag;

    // scoreboard, filled at acceptance and drained at each output handshake
    bf_pkg::beat_u exp_real_q[$];
    bf_pkg::beat_u exp_imag_q[$];
    logic          exp_last_q[$];

    int            error_count = 0;
    int            beats_accepted = 0;
    int            beats_checked = 0;
    logic [31:0]   stim_state = 32'd73;
    logic [31:0]   ready_state = 32'd73;
    // 0 keeps m_ready high, 1 makes it random, 2 holds it low
    int            ready_mode = 0;

    // the stalled beat seen at the last edge
    logic          held_valid;
    bf_pkg::beat_u held_real;
    bf_pkg::beat_u held_imag;
    logic          held_last;

    bf_pkg::chan_beats_t                        xr;
    bf_pkg::chan_beats_t                        xi;
    bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] wr;
    bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] wi;
    int                                         test_start;

    `include "tb_reference.svh"

    beam_former #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) beam_former_i (
        .clock   (clock),
        .resetn  (resetn),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_last  (s_last),
        .s_real  (s_real),
        .s_imag  (s_imag),
        .w_real  (w_real),
        .w_imag  (w_imag),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_last  (m_last),
        .m_real  (m_real),
        .m_imag  (m_imag)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // fills every sample of every channel from the stimulus generator
    task automatic fill_random(output bf_pkg::chan_beats_t beats);
        for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
            for (int s = 0; s < bf_pkg::SAMPLES_PER_BEAT; s++) begin
                stim_state = xorshift(stim_state);
                beats[c].samples[s] = stim_state[15:0];
            end
        end
    endtask

    // drives new weights with s_valid low and gives them a cycle to reach the register
    task automatic set_weights(input bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] real_part,
                               input bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] imag_part);
        w_real = real_part;
        w_imag = imag_part;
        @(negedge clock);
        @(negedge clock);
    endtask

    // the mode changes at a rising edge so the m_ready driver sees it at the next falling one
    task automatic set_ready_mode(input int mode);
        @(posedge clock);
        ready_mode = mode;
        @(negedge clock);
    endtask

    // holds one beat on the input until s_ready takes it, starting and ending on a falling edge
    task automatic send_beat(input bf_pkg::chan_beats_t real_beat,
                             input bf_pkg::chan_beats_t imag_beat, input logic last);
        int waited;
        waited = 0;
        s_valid = 1'b1;
        s_real = real_beat;
        s_imag = imag_beat;
        s_last = last;
        @(posedge clock);
        while (!s_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        if (!s_ready) begin
            $display("at %0t the input beat was never accepted, s_ready stayed low", $time);
            error_count++;
        end
        @(negedge clock);
        s_valid = 1'b0;
        s_last = 1'b0;
    endtask

    // waits until every expected beat has left the DUT
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_real_q.size() != 0 || m_valid) && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clock);
        end
        if (exp_real_q.size() != 0) begin
            $display("at %0t %0d expected beats never came out", $time, exp_real_q.size());
            error_count++;
        end
    endtask

    task automatic report_test(input int number, input string name, input int beats);
        $display("test %0d %s finished with %0d beats and %0d errors", number, name, beats,
                 error_count - test_start);
    endtask

    always @(negedge clock) begin
        ready_state = xorshift(ready_state);
        case (ready_mode)
            1:       m_ready = ready_state[0];
            2:       m_ready = 1'b0;
            default: m_ready = 1'b1;
        endcase
    end

    // the expected beam is worked out from the pins at the moment of acceptance
    always @(posedge clock) begin
        if (resetn && s_valid && s_ready) begin
            exp_real_q.push_back(beam_ref(s_real, s_imag, w_real, w_imag, 1'b0));
            exp_imag_q.push_back(beam_ref(s_real, s_imag, w_real, w_imag, 1'b1));
            exp_last_q.push_back(s_last);
            beats_accepted++;
        end
    end

    // compares every output handshake and checks that a stalled beat does not move
    always @(posedge clock) begin
        if (!resetn) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                check_bit("m_valid", 1'b1, m_valid);
                check_beat("m_real", held_real, m_real);
                check_beat("m_imag", held_imag, m_imag);
                check_bit("m_last", held_last, m_last);
            end
            if (m_valid && m_ready) begin
                if (exp_real_q.size() == 0) begin
                    $display("at %0t an output beat came out that was never sent", $time);
                    error_count++;
                end else begin
                    check_beat("m_real", exp_real_q.pop_front(), m_real);
                    check_beat("m_imag", exp_imag_q.pop_front(), m_imag);
                    check_bit("m_last", exp_last_q.pop_front(), m_last);
                    beats_checked++;
                end
            end
            held_valid = m_valid && !m_ready;
            held_real = m_real;
            held_imag = m_imag;
            held_last = m_last;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("the run did not finish within %0d cycles and was stopped", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clock = 1'b0;
        resetn = 1'b0;
        s_valid = 1'b0;
        s_last = 1'b0;
        s_real = '0;
        s_imag = '0;
        w_real = '0;
        w_imag = '0;
        m_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clock);
        resetn = 1'b1;

        // idle DUT, s_ready must rise and nothing may come out
        test_start = error_count;
        repeat (4) @(posedge clock);
        check_bit("s_ready", 1'b1, s_ready);
        repeat (10) begin
            @(posedge clock);
            check_bit("m_valid", 1'b0, m_valid);
        end
        @(negedge clock);
        report_test(1, "idle after reset", 0);

        // -128 is exactly minus one, so channel 2 passes through negated and divided by four
        test_start = error_count;
        wr = '0;
        wi = '0;
        wr[2] = -8'sd128;
        set_weights(wr, wi);
        for (int i = 0; i < 8; i++) begin
            fill_random(xr);
            fill_random(xi);
            send_beat(xr, xi, i == 7);
        end
        wait_drain();
        report_test(2, "single channel weight", 8);

        test_start = error_count;
        for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
            stim_state = xorshift(stim_state);
            wr[c] = stim_state[7:0];
            wi[c] = stim_state[15:8];
        end
        set_weights(wr, wi);
        for (int i = 0; i < 24; i++) begin
            fill_random(xr);
            fill_random(xi);
            send_beat(xr, xi, i == 23);
        end
        wait_drain();
        report_test(3, "random stream", 24);

        // one beat sits in the output register and the rest fill the buffer
        test_start = error_count;
        set_ready_mode(2);
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            fill_random(xr);
            fill_random(xi);
            send_beat(xr, xi, 1'b0);
        end
        repeat (10) @(posedge clock);
        check_bit("s_ready", 1'b0, s_ready);
        check_bit("m_valid", 1'b1, m_valid);
        ready_mode = 1;
        @(negedge clock);
        for (int i = 0; i < 32 - (FIFO_DEPTH + 1); i++) begin
            fill_random(xr);
            fill_random(xi);
            send_beat(xr, xi, i == 32 - (FIFO_DEPTH + 1) - 1);
        end
        wait_drain();
        set_ready_mode(0);
        report_test(4, "random back-pressure", 32);

        // full-scale inputs with both weight parts at -128 push the products past 16 bits
        test_start = error_count;
        wr = {bf_pkg::NUM_CHANNELS{-8'sd128}};
        wi = {bf_pkg::NUM_CHANNELS{-8'sd128}};
        set_weights(wr, wi);
        for (int i = 0; i < 8; i++) begin
            for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
                for (int s = 0; s < bf_pkg::SAMPLES_PER_BEAT; s++) begin
                    stim_state = xorshift(stim_state);
                    xr[c].samples[s] = stim_state[0] ? 16'sh7fff : 16'sh8000;
                    xi[c].samples[s] = stim_state[1] ? 16'sh7fff : 16'sh8000;
                end
            end
            send_beat(xr, xi, i == 7);
        end
        wait_drain();
        report_test(5, "saturation", 8);

        // end-of-packet on beats 0, 3, 4 and 11
        test_start = error_count;
        for (int i = 0; i < 12; i++) begin
            fill_random(xr);
            fill_random(xi);
            send_beat(xr, xi, i == 0 || i == 3 || i == 4 || i == 11);
        end
        wait_drain();
        report_test(6, "last flag", 12);

        if (beats_accepted != beats_checked) begin
            $display("%0d beats went in but %0d came out", beats_accepted, beats_checked);
            error_count++;
        end
        $display("beats accepted %0d, beats checked %0d, errors %0d", beats_accepted,
                 beats_checked, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src/beam_former.sv
module beam_former #(
    // entries in the beat buffer, any power of two from 4 up
    parameter int FIFO_DEPTH = 4,
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH) + 1
) (
    input  logic                                       clock,
    input  logic                                       resetn,
    input  logic                                       s_valid,
    output logic                                       s_ready,
    input  logic                                       s_last,
    input  bf_pkg::chan_beats_t                        s_real,
    input  bf_pkg::chan_beats_t                        s_imag,
    input  bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] w_real,
    input  bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] w_imag,
    output logic                                       m_valid,
    input  logic                                       m_ready,
    output logic                                       m_last,
    output bf_pkg::beat_u                              m_real,
    output bf_pkg::beat_u                              m_imag
);

    // weighted beats from the multiply pipeline into the buffer
    logic                   wr_en;
    bf_pkg::chan_beats_t    wr_real;
    bf_pkg::chan_beats_t    wr_imag;
    logic                   wr_last;

    // buffer occupancy, which the multiply pipeline turns into its input ready
    logic [COUNT_WIDTH-1:0] fifo_count;

    // head of the buffer towards the combiner
    logic                   rd_en;
    logic                   rd_valid;
    bf_pkg::chan_beats_t    rd_real;
    bf_pkg::chan_beats_t    rd_imag;
    logic                   rd_last;

    // per-channel complex weighting, two beats can be in flight here
    channel_weighting #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) channel_weighting_i (
        .clock      (clock),
        .resetn     (resetn),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .s_last     (s_last),
        .s_real     (s_real),
        .s_imag     (s_imag),
        .w_real     (w_real),
        .w_imag     (w_imag),
        .fifo_count (fifo_count),
        .wr_en      (wr_en),
        .wr_real    (wr_real),
        .wr_imag    (wr_imag),
        .wr_last    (wr_last)
    );

    // absorbs the pipeline contents while the output is stalled
    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) beat_fifo_i (
        .clock      (clock),
        .resetn     (resetn),
        .wr_en      (wr_en),
        .wr_real    (wr_real),
        .wr_imag    (wr_imag),
        .wr_last    (wr_last),
        .rd_en      (rd_en),
        .rd_valid   (rd_valid),
        .rd_real    (rd_real),
        .rd_imag    (rd_imag),
        .rd_last    (rd_last),
        .fifo_count (fifo_count)
    );

    // sums the channels into the single output beam
    beam_combiner beam_combiner_i (
        .clock    (clock),
        .resetn   (resetn),
        .rd_valid (rd_valid),
        .rd_real  (rd_real),
        .rd_imag  (rd_imag),
        .rd_last  (rd_last),
        .rd_en    (rd_en),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_last   (m_last),
        .m_real   (m_real),
        .m_imag   (m_imag)
    );

endmodule

// File: src/beam_combiner.sv
module beam_combiner (
    input  logic                clock,
    input  logic                resetn,
    input  logic                rd_valid,
    input  bf_pkg::chan_beats_t rd_real,
    input  bf_pkg::chan_beats_t rd_imag,
    input  logic                rd_last,
    output logic                rd_en,
    output logic                m_valid,
    input  logic                m_ready,
    output logic                m_last,
    output bf_pkg::beat_u       m_real,
    output bf_pkg::beat_u       m_imag
);

    // four 16-bit samples add up to at most 18 bits
    localparam int SUM_WIDTH = bf_pkg::SAMPLE_WIDTH + 2;

    // sum of one sample position over all channels, divided by four with round-half-up
    function automatic bf_pkg::sample_t combine(input bf_pkg::chan_beats_t beats, input int idx);
        logic signed [SUM_WIDTH-1:0] acc;
        logic signed [SUM_WIDTH-1:0] rounded;
        acc = '0;
        for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
            acc = acc + $signed(beats[c].samples[idx]);
        end
        // adding 2 cannot wrap, the largest sum is 4 * 32767
        rounded = acc + 2;
        // the quotient always lands back inside the 16-bit range
        return bf_pkg::sample_t'(rounded >>> 2);
    endfunction

    // pop the buffer when the output register is free or is handing its beat over
    assign rd_en = rd_valid && (!m_valid || m_ready);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            m_valid <= 1'b0;
        end else if (rd_en) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    // beam data and the end-of-packet flag only change when a new beat is taken
    always_ff @(posedge clock) begin
        if (rd_en) begin
            for (int s = 0; s < bf_pkg::SAMPLES_PER_BEAT; s++) begin
                m_real.samples[s] <= combine(rd_real, s);
                m_imag.samples[s] <= combine(rd_imag, s);
            end
            m_last <= rd_last;
        end
    end

    // a stalled beat must stay put, both the strobe and everything it qualifies
    assert property (@(posedge clock) disable iff (!resetn)
        m_valid && !m_ready |=> m_valid && $stable(m_real.word) && $stable(m_imag.word)
            && $stable(m_last));

endmodule

// File: src/beat_fifo.sv
module beat_fifo #(
    parameter int FIFO_DEPTH = 4,
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH),
    localparam int COUNT_WIDTH = ADDR_WIDTH + 1
) (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   wr_en,
    input  bf_pkg::chan_beats_t    wr_real,
    input  bf_pkg::chan_beats_t    wr_imag,
    input  logic                   wr_last,
    input  logic                   rd_en,
    output logic                   rd_valid,
    output bf_pkg::chan_beats_t    rd_real,
    output bf_pkg::chan_beats_t    rd_imag,
    output logic                   rd_last,
    output logic [COUNT_WIDTH-1:0] fifo_count
);

    // the buffer never looks inside a beat, so each channel is kept as a flat word
    logic [bf_pkg::BEAT_WIDTH-1:0] mem_real [FIFO_DEPTH][bf_pkg::NUM_CHANNELS];
    logic [bf_pkg::BEAT_WIDTH-1:0] mem_imag [FIFO_DEPTH][bf_pkg::NUM_CHANNELS];
    logic                          mem_last [FIFO_DEPTH];

    // pointers wrap on their own because the depth is a power of two
    logic [ADDR_WIDTH-1:0]         wr_ptr;
    logic [ADDR_WIDTH-1:0]         rd_ptr;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
                mem_real[wr_ptr][c] <= wr_real[c].word;
                mem_imag[wr_ptr][c] <= wr_imag[c].word;
            end
            mem_last[wr_ptr] <= wr_last;
        end
    end

    // show-ahead read, the oldest entry is on the outputs before rd_en asks for it
    always_comb begin
        for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
            rd_real[c].word = mem_real[rd_ptr][c];
            rd_imag[c].word = mem_imag[rd_ptr][c];
        end
    end

    assign rd_last = mem_last[rd_ptr];

    // a written entry counts from the next cycle on, which is when rd_valid shows it
    assign rd_valid = fifo_count != '0;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // a write and a read in the same cycle leave the count alone
            case ({wr_en, rd_en})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // the writer's credit scheme is what keeps a full buffer from being written
    assert property (@(posedge clock) disable iff (!resetn)
        fifo_count == COUNT_WIDTH'(FIFO_DEPTH) |-> !wr_en);

    // the combiner may only pop an entry that is really there
    assert property (@(posedge clock) disable iff (!resetn)
        rd_en |-> rd_valid);

endmodule

// File: weighting/channel_weighting.sv
module channel_weighting #(
    parameter int FIFO_DEPTH = 4,
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH) + 1
) (
    input  logic                                       clock,
    input  logic                                       resetn,
    input  logic                                       s_valid,
    output logic                                       s_ready,
    input  logic                                       s_last,
    input  bf_pkg::chan_beats_t                        s_real,
    input  bf_pkg::chan_beats_t                        s_imag,
    input  bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] w_real,
    input  bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] w_imag,
    input  logic [COUNT_WIDTH-1:0]                     fifo_count,
    output logic                                       wr_en,
    output bf_pkg::chan_beats_t                        wr_real,
    output bf_pkg::chan_beats_t                        wr_imag,
    output logic                                       wr_last
);

    // a 16 by 8 bit signed product needs 24 bits
    localparam int PRODUCT_WIDTH = bf_pkg::SAMPLE_WIDTH + bf_pkg::WEIGHT_WIDTH;
    // one more bit so the sum or difference of two products cannot wrap
    localparam int ACC_WIDTH = PRODUCT_WIDTH + 1;
    localparam int FRAC_BITS = bf_pkg::WEIGHT_WIDTH - 1;
    localparam int SHIFTED_WIDTH = ACC_WIDTH - FRAC_BITS;

    // adds one half of the last kept bit, drops the weight fraction, then clamps to 16 bits
    function automatic bf_pkg::sample_t round_sat(input logic signed [ACC_WIDTH-1:0] acc);
        logic signed [ACC_WIDTH-1:0]     rounded;
        logic signed [SHIFTED_WIDTH-1:0] shifted;
        logic                            fits;
        rounded = acc + (ACC_WIDTH'(1) << (FRAC_BITS - 1));
        shifted = SHIFTED_WIDTH'(rounded >>> FRAC_BITS);
        // the value fits when every bit above the sample's sign bit copies that sign bit
        fits = (&shifted[SHIFTED_WIDTH-1:bf_pkg::SAMPLE_WIDTH-1])
            || (~|shifted[SHIFTED_WIDTH-1:bf_pkg::SAMPLE_WIDTH-1]);
        if (fits) begin
            return shifted[bf_pkg::SAMPLE_WIDTH-1:0];
        end
        // out of range, so clamp to the most positive or most negative sample
        return {shifted[SHIFTED_WIDTH-1], {(bf_pkg::SAMPLE_WIDTH-1){~shifted[SHIFTED_WIDTH-1]}}};
    endfunction

    // weights in use, one register stage behind the input pins
    bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] w_real_q;
    bf_pkg::weight_t [bf_pkg::NUM_CHANNELS-1:0] w_imag_q;

    // stage one holds the four partial products of every sample of every channel
    logic signed [PRODUCT_WIDTH-1:0] prod_rr [bf_pkg::NUM_CHANNELS][bf_pkg::SAMPLES_PER_BEAT];
    logic signed [PRODUCT_WIDTH-1:0] prod_ii [bf_pkg::NUM_CHANNELS][bf_pkg::SAMPLES_PER_BEAT];
    logic signed [PRODUCT_WIDTH-1:0] prod_ri [bf_pkg::NUM_CHANNELS][bf_pkg::SAMPLES_PER_BEAT];
    logic signed [PRODUCT_WIDTH-1:0] prod_ir [bf_pkg::NUM_CHANNELS][bf_pkg::SAMPLES_PER_BEAT];
    logic                            stage1_valid;
    logic                            stage1_last;

    logic                            accept;
    logic [COUNT_WIDTH:0]            credit_used;

    assign accept = s_valid && s_ready;

    // buffered beats, beats in both stages and the beat accepted right now
    // reads are left out, so the count can only be too high and never too low
    assign credit_used = {1'b0, fifo_count}
        + {{COUNT_WIDTH{1'b0}}, stage1_valid}
        + {{COUNT_WIDTH{1'b0}}, wr_en}
        + {{COUNT_WIDTH{1'b0}}, accept};

    // new weights take effect one cycle after they show up on the pins
    always_ff @(posedge clock) begin
        w_real_q <= w_real;
        w_imag_q <= w_imag;
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            stage1_valid <= 1'b0;
            wr_en        <= 1'b0;
            s_ready      <= 1'b0;
        end else begin
            stage1_valid <= accept;
            wr_en        <= stage1_valid;
            // ready next cycle only if one more beat still has a free buffer entry waiting
            s_ready      <= credit_used < (COUNT_WIDTH + 1)'(FIFO_DEPTH);
        end
    end

    // stage one, wr*xr and wi*xi feed the real part, wr*xi and wi*xr the imaginary part
    always_ff @(posedge clock) begin
        if (accept) begin
            for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
                for (int s = 0; s < bf_pkg::SAMPLES_PER_BEAT; s++) begin
                    prod_rr[c][s] <= $signed(w_real_q[c]) * $signed(s_real[c].samples[s]);
                    prod_ii[c][s] <= $signed(w_imag_q[c]) * $signed(s_imag[c].samples[s]);
                    prod_ri[c][s] <= $signed(w_real_q[c]) * $signed(s_imag[c].samples[s]);
                    prod_ir[c][s] <= $signed(w_imag_q[c]) * $signed(s_real[c].samples[s]);
                end
            end
            stage1_last <= s_last;
        end
    end

    // stage two forms the complex product and brings it back to sample width
    always_ff @(posedge clock) begin
        if (stage1_valid) begin
            for (int c = 0; c < bf_pkg::NUM_CHANNELS; c++) begin
                for (int s = 0; s < bf_pkg::SAMPLES_PER_BEAT; s++) begin
                    wr_real[c].samples[s] <= round_sat(prod_rr[c][s] - prod_ii[c][s]);
                    wr_imag[c].samples[s] <= round_sat(prod_ri[c][s] + prod_ir[c][s]);
                end
            end
            wr_last <= stage1_last;
        end
    end

    // the credit count has to keep every write away from a full buffer
    assert property (@(posedge clock) disable iff (!resetn)
        wr_en |-> fifo_count < COUNT_WIDTH'(FIFO_DEPTH));

endmodule

// File: common/bf_pkg.sv
package bf_pkg;

    // bits in one real or one imaginary sample
    localparam int SAMPLE_WIDTH = 16;

    // bits in the real or the imaginary part of a channel weight
    // the weight is a signed fraction with seven fraction bits, so 127 is just under one
    localparam int WEIGHT_WIDTH = 8;

    // complex samples carried side by side in one beat
    localparam int SAMPLES_PER_BEAT = 8;

    // antenna channels that feed the beam
    localparam int NUM_CHANNELS = 4;

    // bits in the real or the imaginary half of one channel beat
    localparam int BEAT_WIDTH = SAMPLE_WIDTH * SAMPLES_PER_BEAT;

    // one signed sample, real or imaginary
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // one signed weight part, real or imaginary
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // one beat of one channel, real or imaginary half
    // the ports and the FIFO memory see it as a flat word, while the arithmetic picks the
    // samples out of it one by one
    // sample 0 sits in the lowest 16 bits of the word
    typedef union packed {
        logic [BEAT_WIDTH-1:0] word;
        sample_t [SAMPLES_PER_BEAT-1:0] samples;
    } beat_u;

    // the real or the imaginary half of one beat across all channels
    // channel 0 is the lowest beat in the vector
    typedef beat_u [NUM_CHANNELS-1:0] chan_beats_t;

endpackage
